//--- kickman_glue_pkg.sv
// shared types and constants; scancodes are PS/2 set 2, STORE_LATENCY must stay 2 or more
package kickman_glue_pkg;

	// ====================
	// data and address widths
	// ====================
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [14:0] cpu_addr_t;
	typedef logic [13:0] snd_addr_t;
	// sound region only uses the low 13 bits
	typedef logic [13:0] word_addr_t;
	// bit 1 selects the high byte
	typedef logic [1:0]  strobe_t;
	typedef logic [7:0]  scancode_t;
	typedef logic [7:0]  joy_t;
	typedef logic [15:0] sample_t;

	// ====================
	// ROM layout and timing
	// ====================
	// sound ROM starts at byte 0x6000 of the download
	localparam int SND_WORD_OFFSET = 'h3000;
	localparam int CPU_ROM_WORDS = 16384;
	localparam int SND_ROM_WORDS = 8192;
	// req toggle to ack toggle
	localparam int STORE_LATENCY = 2;

	// ====================
	// controls
	// ====================
	// joystick bit positions
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT = 1;
	localparam int JOY_DOWN = 2;
	localparam int JOY_UP = 3;
	localparam int JOY_FIRE = 4;

	localparam scancode_t KEY_UP = 8'h75;
	localparam scancode_t KEY_DOWN = 8'h72;
	localparam scancode_t KEY_LEFT = 8'h6B;
	localparam scancode_t KEY_RIGHT = 8'h74;
	// esc
	localparam scancode_t KEY_COIN = 8'h76;
	// f1 and f2
	localparam scancode_t KEY_START1 = 8'h05;
	localparam scancode_t KEY_START2 = 8'h06;
	// space
	localparam scancode_t KEY_FIRE = 8'h29;

endpackage

//--- rom_port_if.sv
// one toggle-handshake ROM port; a request is pending while req differs from ack
`timescale 1ns/1ns

interface rom_port_if;
	import kickman_glue_pkg::*;

	// request toggle, flipped once per operation
	logic req;
	// acknowledge toggle, catches up with req when done
	logic ack;

	// operation, stable while a request is pending
	word_addr_t addr;
	strobe_t ds;
	logic we;
	word_t d;

	// read word, valid once ack matches req
	word_t q;

	modport requester (
		output req,
		output addr,
		output ds,
		output we,
		output d,
		input  ack,
		input  q
	);

	modport store (
		input  req,
		input  addr,
		input  ds,
		input  we,
		input  d,
		output ack,
		output q
	);

endinterface

//--- rom_access_ctrl.sv
// download writes must be spaced 4 or more cycles apart; rst does not clear rom_loaded
`timescale 1ns/1ns

module rom_access_ctrl (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  logic                       user_reset,
	input  logic                       ioctl_download,
	input  logic                       ioctl_wr,
	input  kickman_glue_pkg::dl_addr_t  ioctl_addr,
	input  kickman_glue_pkg::byte_t     ioctl_dout,
	input  kickman_glue_pkg::cpu_addr_t cpu_rom_addr,
	input  logic                       cpu_rom_rd,
	input  kickman_glue_pkg::snd_addr_t snd_rom_addr,
	input  logic                       snd_rom_rd,
	rom_port_if.requester              cpu_port,
	rom_port_if.requester              snd_port,
	output kickman_glue_pkg::byte_t     cpu_rom_data,
	output logic                       cpu_rom_valid,
	output kickman_glue_pkg::byte_t     snd_rom_data,
	output logic                       snd_rom_valid,
	output logic                       game_reset
);
	import kickman_glue_pkg::*;

	typedef logic [$bits(dl_addr_t)-2:0] dl_word_t;

	dl_word_t dl_word;
	dl_word_t dl_snd_word;
	logic dl_cpu_hit;
	logic dl_snd_hit;
	strobe_t dl_ds;
	logic wr_prev;
	logic dl_prev;
	logic wr_go;
	logic rom_loaded = 1'b0;

	word_addr_t cpu_word, snd_word;
	word_addr_t cpu_last, snd_last;
	word_addr_t cpu_hold_addr, snd_hold_addr;
	word_addr_t cpu_rd_addr, snd_rd_addr;
	logic cpu_pend, snd_pend;
	logic cpu_new, snd_new;
	logic cpu_hold, snd_hold;
	logic cpu_hold_lsb, snd_hold_lsb;
	logic cpu_rd_go, snd_rd_go;
	logic cpu_rd_lsb, snd_rd_lsb;
	logic cpu_busy, snd_busy;
	logic cpu_lsb, snd_lsb;

	// ====================
	// download address split
	// ====================
	assign dl_word = ioctl_addr[$bits(dl_addr_t)-1:1];
	assign dl_snd_word = dl_word - dl_word_t'(SND_WORD_OFFSET);
	// bytes outside a region go out with no strobes
	assign dl_cpu_hit = dl_word < dl_word_t'(CPU_ROM_WORDS);
	assign dl_snd_hit = (dl_word >= dl_word_t'(SND_WORD_OFFSET)) &&
		(dl_snd_word < dl_word_t'(SND_ROM_WORDS));
	assign dl_ds = {ioctl_addr[0], ~ioctl_addr[0]};
	assign wr_go = ioctl_download & ioctl_wr & ~wr_prev;

	// ====================
	// read request decisions
	// ====================
	assign cpu_word = cpu_rom_addr[$bits(cpu_addr_t)-1:1];
	assign snd_word = word_addr_t'(snd_rom_addr[$bits(snd_addr_t)-1:1]);
	assign cpu_pend = cpu_port.req != cpu_port.ack;
	assign snd_pend = snd_port.req != snd_port.ack;
	assign cpu_new = cpu_rom_rd && (cpu_word != cpu_last);
	assign snd_new = snd_rom_rd && (snd_word != snd_last);
	// a fresh address wins over a held one
	assign cpu_rd_go = !ioctl_download && !cpu_pend && (cpu_new || cpu_hold);
	assign snd_rd_go = !ioctl_download && !snd_pend && (snd_new || snd_hold);
	assign cpu_rd_addr = cpu_new ? cpu_word : cpu_hold_addr;
	assign snd_rd_addr = snd_new ? snd_word : snd_hold_addr;
	assign cpu_rd_lsb = cpu_new ? cpu_rom_addr[0] : cpu_hold_lsb;
	assign snd_rd_lsb = snd_new ? snd_rom_addr[0] : snd_hold_lsb;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_prev <= 1'b0;
			dl_prev <= 1'b0;
			cpu_port.req <= 1'b0;
			snd_port.req <= 1'b0;
			cpu_last <= '1;
			snd_last <= '1;
			cpu_hold <= 1'b0;
			snd_hold <= 1'b0;
			cpu_busy <= 1'b0;
			snd_busy <= 1'b0;
			cpu_rom_valid <= 1'b0;
			snd_rom_valid <= 1'b0;
		end else begin
			wr_prev <= ioctl_wr;
			dl_prev <= ioctl_download;
			if (wr_go || cpu_rd_go) begin
				cpu_port.req <= ~cpu_port.req;
			end
			if (wr_go || snd_rd_go) begin
				snd_port.req <= ~snd_port.req;
			end
			// all ones so the first read after download always goes out
			if (ioctl_download) begin
				cpu_last <= '1;
				snd_last <= '1;
			end else begin
				if (cpu_new) begin
					cpu_last <= cpu_word;
				end
				if (snd_new) begin
					snd_last <= snd_word;
				end
			end
			cpu_hold <= !ioctl_download && (cpu_new || cpu_hold) && cpu_pend;
			snd_hold <= !ioctl_download && (snd_new || snd_hold) && snd_pend;
			cpu_busy <= cpu_rd_go || (cpu_busy && cpu_pend);
			snd_busy <= snd_rd_go || (snd_busy && snd_pend);
			cpu_rom_valid <= cpu_busy && !cpu_pend;
			snd_rom_valid <= snd_busy && !snd_pend;
		end
	end

	// port payload, changed only together with req
	always_ff @(posedge clk_sys) begin
		if (wr_go) begin
			cpu_port.addr <= dl_word[$bits(word_addr_t)-1:0];
			cpu_port.ds <= dl_cpu_hit ? dl_ds : '0;
			cpu_port.we <= 1'b1;
			cpu_port.d <= {ioctl_dout, ioctl_dout};
			snd_port.addr <= dl_snd_word[$bits(word_addr_t)-1:0];
			snd_port.ds <= dl_snd_hit ? dl_ds : '0;
			snd_port.we <= 1'b1;
			snd_port.d <= {ioctl_dout, ioctl_dout};
		end
		if (cpu_rd_go) begin
			cpu_port.addr <= cpu_rd_addr;
			cpu_port.ds <= '1;
			cpu_port.we <= 1'b0;
			cpu_lsb <= cpu_rd_lsb;
		end
		if (snd_rd_go) begin
			snd_port.addr <= snd_rd_addr;
			snd_port.ds <= '1;
			snd_port.we <= 1'b0;
			snd_lsb <= snd_rd_lsb;
		end
		if (cpu_new) begin
			cpu_hold_addr <= cpu_word;
			cpu_hold_lsb <= cpu_rom_addr[0];
		end
		if (snd_new) begin
			snd_hold_addr <= snd_word;
			snd_hold_lsb <= snd_rom_addr[0];
		end
		// odd byte address takes the high byte
		if (cpu_busy && !cpu_pend) begin
			cpu_rom_data <= cpu_lsb ? cpu_port.q[15:8] : cpu_port.q[7:0];
		end
		if (snd_busy && !snd_pend) begin
			snd_rom_data <= snd_lsb ? snd_port.q[15:8] : snd_port.q[7:0];
		end
	end

	// ====================
	// game reset
	// ====================
	always_ff @(posedge clk_sys) begin
		if (dl_prev && !ioctl_download) begin
			rom_loaded <= 1'b1;
		end
		game_reset <= rst | user_reset | ~rom_loaded;
	end

endmodule

//--- rom_store.sv
// on-chip stand-in for the SDRAM; STORE_LATENCY must be 2 or more, contents survive rst
`timescale 1ns/1ns

module rom_store (
	input  logic      clk_sys,
	input  logic      rst,
	rom_port_if.store cpu_port,
	rom_port_if.store snd_port
);
	import kickman_glue_pkg::*;

	localparam int STAGES = STORE_LATENCY - 1;
	localparam int CPU_AW = $clog2(CPU_ROM_WORDS);
	localparam int SND_AW = $clog2(SND_ROM_WORDS);

	word_t cpu_mem [CPU_ROM_WORDS];
	word_t snd_mem [SND_ROM_WORDS];

	// last req level seen, and the delay line behind it
	logic cpu_seen, snd_seen;
	logic [STAGES-1:0] cpu_pipe, snd_pipe;

	// operation taken when the toggle is seen
	word_addr_t cpu_op_addr, snd_op_addr;
	strobe_t cpu_op_ds, snd_op_ds;
	logic cpu_op_we, snd_op_we;
	word_t cpu_op_d, snd_op_d;

	function automatic logic in_region(word_addr_t a, int words);
		return int'(a) < words;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cpu_seen <= 1'b0;
			snd_seen <= 1'b0;
			cpu_pipe <= '0;
			snd_pipe <= '0;
			cpu_port.ack <= 1'b0;
			snd_port.ack <= 1'b0;
		end else begin
			cpu_seen <= cpu_port.req;
			snd_seen <= snd_port.req;
			cpu_pipe[0] <= cpu_port.req != cpu_seen;
			snd_pipe[0] <= snd_port.req != snd_seen;
			for (int i = 1; i < STAGES; i++) begin
				cpu_pipe[i] <= cpu_pipe[i-1];
				snd_pipe[i] <= snd_pipe[i-1];
			end
			// answer leaves the end of the delay line
			if (cpu_pipe[STAGES-1]) begin
				cpu_port.ack <= ~cpu_port.ack;
			end
			if (snd_pipe[STAGES-1]) begin
				snd_port.ack <= ~snd_port.ack;
			end
		end
	end

	// ====================
	// memory access
	// ====================
	always_ff @(posedge clk_sys) begin
		if (cpu_port.req != cpu_seen) begin
			cpu_op_addr <= cpu_port.addr;
			cpu_op_ds <= cpu_port.ds;
			cpu_op_we <= cpu_port.we;
			cpu_op_d <= cpu_port.d;
		end
		if (snd_port.req != snd_seen) begin
			snd_op_addr <= snd_port.addr;
			snd_op_ds <= snd_port.ds;
			snd_op_we <= snd_port.we;
			snd_op_d <= snd_port.d;
		end
		if (cpu_pipe[STAGES-1]) begin
			cpu_port.q <= cpu_mem[cpu_op_addr[CPU_AW-1:0]];
			if (cpu_op_we && in_region(cpu_op_addr, CPU_ROM_WORDS)) begin
				if (cpu_op_ds[0]) begin
					cpu_mem[cpu_op_addr[CPU_AW-1:0]][7:0] <= cpu_op_d[7:0];
				end
				if (cpu_op_ds[1]) begin
					cpu_mem[cpu_op_addr[CPU_AW-1:0]][15:8] <= cpu_op_d[15:8];
				end
			end
		end
		if (snd_pipe[STAGES-1]) begin
			snd_port.q <= snd_mem[snd_op_addr[SND_AW-1:0]];
			if (snd_op_we && in_region(snd_op_addr, SND_ROM_WORDS)) begin
				if (snd_op_ds[0]) begin
					snd_mem[snd_op_addr[SND_AW-1:0]][7:0] <= snd_op_d[7:0];
				end
				if (snd_op_ds[1]) begin
					snd_mem[snd_op_addr[SND_AW-1:0]][15:8] <= snd_op_d[15:8];
				end
			end
		end
	end

endmodule

//--- control_mapper.sv
// keys latch on key_strobe; without rotate the directions are turned for the upright cabinet
`timescale 1ns/1ns

module control_mapper (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  logic                       key_strobe,
	input  logic                       key_pressed,
	input  kickman_glue_pkg::scancode_t key_code,
	input  kickman_glue_pkg::joy_t      joystick_0,
	input  kickman_glue_pkg::joy_t      joystick_1,
	input  logic                       rotate,
	output logic                       coin1,
	output logic                       start1,
	output logic                       start2,
	output logic                       kick,
	output logic                       btn_acc,
	output logic                       btn_left,
	output logic                       btn_right
);
	import kickman_glue_pkg::*;

	// key states
	logic held_up, held_down, held_left, held_right;
	logic held_coin, held_start1, held_start2, held_fire;
	// keyboard or either joystick
	logic dir_up, dir_down, dir_left, dir_right, dir_fire;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			held_up <= 1'b0;
			held_down <= 1'b0;
			held_left <= 1'b0;
			held_right <= 1'b0;
			held_coin <= 1'b0;
			held_start1 <= 1'b0;
			held_start2 <= 1'b0;
			held_fire <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_UP:     held_up <= key_pressed;
				KEY_DOWN:   held_down <= key_pressed;
				KEY_LEFT:   held_left <= key_pressed;
				KEY_RIGHT:  held_right <= key_pressed;
				KEY_COIN:   held_coin <= key_pressed;
				KEY_START1: held_start1 <= key_pressed;
				KEY_START2: held_start2 <= key_pressed;
				KEY_FIRE:   held_fire <= key_pressed;
				default:    ;
			endcase
		end
	end

	assign dir_up = held_up | joystick_0[JOY_UP] | joystick_1[JOY_UP];
	assign dir_down = held_down | joystick_0[JOY_DOWN] | joystick_1[JOY_DOWN];
	assign dir_left = held_left | joystick_0[JOY_LEFT] | joystick_1[JOY_LEFT];
	assign dir_right = held_right | joystick_0[JOY_RIGHT] | joystick_1[JOY_RIGHT];
	assign dir_fire = held_fire | joystick_0[JOY_FIRE] | joystick_1[JOY_FIRE];

	// ====================
	// game buttons
	// ====================
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			kick <= 1'b0;
			btn_left <= 1'b0;
			btn_right <= 1'b0;
			btn_acc <= 1'b0;
			coin1 <= 1'b0;
			start1 <= 1'b0;
			start2 <= 1'b0;
		end else begin
			kick <= rotate ? dir_down : dir_right;
			btn_left <= rotate ? dir_left : dir_down;
			btn_right <= rotate ? dir_right : dir_up;
			btn_acc <= dir_fire;
			coin1 <= held_coin;
			start1 <= held_start1;
			start2 <= held_start2;
		end
	end

endmodule

//--- sigma_delta_dac.sv
// first-order one-bit DAC; sample is unsigned, ones density is sample / 2**DAC_WIDTH
`timescale 1ns/1ns

module sigma_delta_dac #(
	parameter int DAC_WIDTH = 16
) (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  logic [DAC_WIDTH-1:0] sample,
	output logic                 bit_out
);

	// ====================
	// accumulator
	// ====================
	// top bit holds the carry of the last add
	logic [DAC_WIDTH:0] acc;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc <= '0;
		end else begin
			// residue only, the old carry is dropped
			acc <= {1'b0, acc[DAC_WIDTH-1:0]} + {1'b0, sample};
		end
	end

	// carry is the pulse stream
	assign bit_out = acc[DAC_WIDTH];

endmodule

//--- kickman_glue_top.sv
// glue around the game core; the core, video, config link and PLL live outside this block
`timescale 1ns/1ns

module kickman_glue_top (
	input  logic                       clk_sys,
	input  logic                       rst,
	input  logic                       user_reset,
	input  logic                       ioctl_download,
	input  logic                       ioctl_wr,
	input  kickman_glue_pkg::dl_addr_t  ioctl_addr,
	input  kickman_glue_pkg::byte_t     ioctl_dout,
	input  kickman_glue_pkg::cpu_addr_t cpu_rom_addr,
	input  logic                       cpu_rom_rd,
	input  kickman_glue_pkg::snd_addr_t snd_rom_addr,
	input  logic                       snd_rom_rd,
	input  logic                       key_strobe,
	input  logic                       key_pressed,
	input  kickman_glue_pkg::scancode_t key_code,
	input  kickman_glue_pkg::joy_t      joystick_0,
	input  kickman_glue_pkg::joy_t      joystick_1,
	input  logic                       rotate,
	input  kickman_glue_pkg::sample_t   audio_l_in,
	input  kickman_glue_pkg::sample_t   audio_r_in,
	output kickman_glue_pkg::byte_t     cpu_rom_data,
	output logic                       cpu_rom_valid,
	output kickman_glue_pkg::byte_t     snd_rom_data,
	output logic                       snd_rom_valid,
	output logic                       game_reset,
	output logic                       coin1,
	output logic                       start1,
	output logic                       start2,
	output logic                       kick,
	output logic                       btn_acc,
	output logic                       btn_left,
	output logic                       btn_right,
	output logic                       audio_l,
	output logic                       audio_r
);
	import kickman_glue_pkg::*;

	localparam int DAC_WIDTH = $bits(sample_t);

	// ====================
	// ROM path
	// ====================
	rom_port_if cpu_port ();
	rom_port_if snd_port ();

	rom_access_ctrl i_rom_access_ctrl (
		.clk_sys        (clk_sys),
		.rst            (rst),
		.user_reset     (user_reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.cpu_rom_addr   (cpu_rom_addr),
		.cpu_rom_rd     (cpu_rom_rd),
		.snd_rom_addr   (snd_rom_addr),
		.snd_rom_rd     (snd_rom_rd),
		.cpu_port       (cpu_port.requester),
		.snd_port       (snd_port.requester),
		.cpu_rom_data   (cpu_rom_data),
		.cpu_rom_valid  (cpu_rom_valid),
		.snd_rom_data   (snd_rom_data),
		.snd_rom_valid  (snd_rom_valid),
		.game_reset     (game_reset)
	);

	rom_store i_rom_store (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.cpu_port (cpu_port.store),
		.snd_port (snd_port.store)
	);

	// ====================
	// controls and audio
	// ====================
	control_mapper i_control_mapper (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.rotate      (rotate),
		.coin1       (coin1),
		.start1      (start1),
		.start2      (start2),
		.kick        (kick),
		.btn_acc     (btn_acc),
		.btn_left    (btn_left),
		.btn_right   (btn_right)
	);

	sigma_delta_dac #(.DAC_WIDTH(DAC_WIDTH)) dac_l (
		.clk_sys (clk_sys),
		.rst     (rst),
		.sample  (audio_l_in),
		.bit_out (audio_l)
	);

	sigma_delta_dac #(.DAC_WIDTH(DAC_WIDTH)) dac_r (
		.clk_sys (clk_sys),
		.rst     (rst),
		.sample  (audio_r_in),
		.bit_out (audio_r)
	);

endmodule

//--- kickman_glue_asserts.sv
// handshake checks bound into rom_access_ctrl; all properties are off while rst is high
`timescale 1ns/1ns

module kickman_glue_asserts (
	input logic                         clk_sys,
	input logic                         rst,
	input logic                         cpu_req,
	input logic                         cpu_ack,
	input kickman_glue_pkg::word_addr_t cpu_addr,
	input logic                         cpu_valid,
	input logic                         snd_req,
	input logic                         snd_ack,
	input kickman_glue_pkg::word_addr_t snd_addr,
	input logic                         snd_valid
);

	// ====================
	// CPU port
	// ====================
	cpu_req_idle: assert property (@(posedge clk_sys) disable iff (rst)
		(cpu_req != $past(cpu_req)) |-> ($past(cpu_req) == $past(cpu_ack)))
		else $error("CPU req flipped while a request was pending");

	// no flip at the last edge, so the payload must not move
	cpu_addr_stable: assert property (@(posedge clk_sys) disable iff (rst)
		((cpu_req != cpu_ack) && (cpu_req == $past(cpu_req))) |-> (cpu_addr == $past(cpu_addr)))
		else $error("CPU addr changed while a request was pending");

	cpu_valid_pulse: assert property (@(posedge clk_sys) disable iff (rst)
		cpu_valid |=> !cpu_valid)
		else $error("cpu_rom_valid high for more than one cycle");

	// ====================
	// sound port
	// ====================
	snd_req_idle: assert property (@(posedge clk_sys) disable iff (rst)
		(snd_req != $past(snd_req)) |-> ($past(snd_req) == $past(snd_ack)))
		else $error("sound req flipped while a request was pending");

	snd_addr_stable: assert property (@(posedge clk_sys) disable iff (rst)
		((snd_req != snd_ack) && (snd_req == $past(snd_req))) |-> (snd_addr == $past(snd_addr)))
		else $error("sound addr changed while a request was pending");

	snd_valid_pulse: assert property (@(posedge clk_sys) disable iff (rst)
		snd_valid |=> !snd_valid)
		else $error("snd_rom_valid high for more than one cycle");

endmodule

bind rom_access_ctrl kickman_glue_asserts i_asserts (
	.clk_sys   (clk_sys),
	.rst       (rst),
	.cpu_req   (cpu_port.req),
	.cpu_ack   (cpu_port.ack),
	.cpu_addr  (cpu_port.addr),
	.cpu_valid (cpu_rom_valid),
	.snd_req   (snd_port.req),
	.snd_ack   (snd_port.ack),
	.snd_addr  (snd_port.addr),
	.snd_valid (snd_rom_valid)
);

//--- tb_kickman_glue.sv
// directed testbench; only downloaded bytes are read back, the full run takes about 67k cycles
`timescale 1ns/1ns

module tb_kickman_glue;
	import kickman_glue_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int WAIT_LIMIT = 32;
	localparam int SND_BYTE_BASE = 2 * SND_WORD_OFFSET;

	logic clk_sys;
	logic rst;
	logic user_reset;
	logic ioctl_download;
	logic ioctl_wr;
	dl_addr_t ioctl_addr;
	byte_t ioctl_dout;
	cpu_addr_t cpu_rom_addr;
	logic cpu_rom_rd;
	snd_addr_t snd_rom_addr;
	logic snd_rom_rd;
	logic key_strobe;
	logic key_pressed;
	scancode_t key_code;
	joy_t joystick_0;
	joy_t joystick_1;
	logic rotate;
	sample_t audio_l_in;
	sample_t audio_r_in;
	byte_t cpu_rom_data;
	logic cpu_rom_valid;
	byte_t snd_rom_data;
	logic snd_rom_valid;
	logic game_reset;
	logic coin1, start1, start2, kick, btn_acc, btn_left, btn_right;
	logic audio_l, audio_r;

	// byte images of both ROM regions
	byte_t cpu_model [2*CPU_ROM_WORDS];
	byte_t snd_model [2*SND_ROM_WORDS];
	logic [31:0] rng_state;

	kickman_glue_top i_dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ====================
	// helpers and compares
	// ====================
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic stop_run();
		$display("TB FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_byte(input string what, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input string what, input sample_t got, input sample_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		rst = 1'b0;
	endtask

	// one byte per write pulse, six cycles apart
	task automatic write_byte(input dl_addr_t a, input byte_t b);
		ioctl_addr = a;
		ioctl_dout = b;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		repeat (5) @(negedge clk_sys);
		if (int'(a) < 2 * CPU_ROM_WORDS) begin
			cpu_model[int'(a)] = b;
		end
		if (int'(a) >= SND_BYTE_BASE && int'(a) < SND_BYTE_BASE + 2 * SND_ROM_WORDS) begin
			snd_model[int'(a) - SND_BYTE_BASE] = b;
		end
	endtask

	task automatic download_block(input dl_addr_t base, input int count);
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < count; i++) begin
			rng_state = next_random(rng_state);
			write_byte(base + dl_addr_t'(i), rng_state[7:0]);
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic wait_rom_valid(input logic is_snd, output sample_t cycles);
		logic seen;
		seen = 1'b0;
		cycles = '0;
		for (int n = 1; n <= WAIT_LIMIT && !seen; n++) begin
			@(negedge clk_sys);
			cycles = sample_t'(n);
			seen = is_snd ? snd_rom_valid : cpu_rom_valid;
		end
		if (!seen) begin
			$display("timeout: no %s valid pulse within %0d cycles at %0t ns",
				is_snd ? "sound" : "CPU", WAIT_LIMIT, $time);
			stop_run();
		end
	endtask

	task automatic read_cpu(input cpu_addr_t a);
		sample_t cycles;
		cpu_rom_addr = a;
		cpu_rom_rd = 1'b1;
		wait_rom_valid(1'b0, cycles);
		check_count("CPU read latency", cycles, sample_t'(4));
		check_byte("cpu_rom_data", cpu_rom_data, cpu_model[int'(a)]);
	endtask

	task automatic read_snd(input snd_addr_t a);
		sample_t cycles;
		snd_rom_addr = a;
		snd_rom_rd = 1'b1;
		wait_rom_valid(1'b1, cycles);
		check_count("sound read latency", cycles, sample_t'(4));
		check_byte("snd_rom_data", snd_rom_data, snd_model[int'(a)]);
	endtask

	// ====================
	// tests
	// ====================
	task automatic test_reset_hold();
		repeat (4) begin
			@(negedge clk_sys);
			check_bit("game_reset before download", game_reset, 1'b1);
		end
		ioctl_download = 1'b1;
		repeat (3) @(negedge clk_sys);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check_bit("game_reset one cycle after download", game_reset, 1'b1);
		@(negedge clk_sys);
		check_bit("game_reset after download", game_reset, 1'b0);
		user_reset = 1'b1;
		@(negedge clk_sys);
		check_bit("game_reset on user reset", game_reset, 1'b1);
		user_reset = 1'b0;
		@(negedge clk_sys);
		check_bit("game_reset after user reset", game_reset, 1'b0);
	endtask

	// even bytes first so every read moves to a new word
	task automatic test_cpu_read();
		download_block('0, 64);
		for (int i = 0; i < 64; i += 2) begin
			read_cpu(cpu_addr_t'(i));
		end
		for (int i = 1; i < 64; i += 2) begin
			read_cpu(cpu_addr_t'(i));
		end
		cpu_rom_rd = 1'b0;
	endtask

	task automatic test_snd_offset();
		download_block(dl_addr_t'(SND_BYTE_BASE), 32);
		for (int i = 0; i < 32; i += 2) begin
			read_snd(snd_addr_t'(i));
		end
		for (int i = 1; i < 32; i += 2) begin
			read_snd(snd_addr_t'(i));
		end
		snd_rom_rd = 1'b0;
	endtask

	task automatic test_repeat_addr();
		read_cpu(cpu_addr_t'(10));
		repeat (8) begin
			@(negedge clk_sys);
			check_bit("cpu_rom_valid on held address", cpu_rom_valid, 1'b0);
		end
		// other byte of word 5
		cpu_rom_addr = cpu_addr_t'(11);
		repeat (8) begin
			@(negedge clk_sys);
			check_bit("cpu_rom_valid on same word", cpu_rom_valid, 1'b0);
		end
		check_byte("cpu_rom_data kept", cpu_rom_data, cpu_model[10]);
		cpu_rom_rd = 1'b0;
	endtask

	task automatic set_key(input scancode_t code, input logic pressed);
		key_code = code;
		key_pressed = pressed;
		key_strobe = 1'b1;
		@(negedge clk_sys);
		key_strobe = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic set_joy(input joy_t j0, input joy_t j1, input logic rot);
		joystick_0 = j0;
		joystick_1 = j1;
		rotate = rot;
		repeat (2) @(negedge clk_sys);
	endtask

	// order is coin1, start1, start2, kick, btn_acc, btn_left, btn_right
	task automatic expect_buttons(input logic [6:0] exp);
		check_bit("coin1", coin1, exp[6]);
		check_bit("start1", start1, exp[5]);
		check_bit("start2", start2, exp[4]);
		check_bit("kick", kick, exp[3]);
		check_bit("btn_acc", btn_acc, exp[2]);
		check_bit("btn_left", btn_left, exp[1]);
		check_bit("btn_right", btn_right, exp[0]);
	endtask

	task automatic test_controls();
		set_joy(8'h00, 8'h00, 1'b0);
		expect_buttons(7'b0000000);
		// rotated cabinet
		set_key(KEY_RIGHT, 1'b1);
		expect_buttons(7'b0001000);
		set_key(KEY_RIGHT, 1'b0);
		set_key(KEY_DOWN, 1'b1);
		expect_buttons(7'b0000010);
		set_key(KEY_DOWN, 1'b0);
		set_key(KEY_UP, 1'b1);
		expect_buttons(7'b0000001);
		set_key(KEY_UP, 1'b0);
		set_joy(8'h08, 8'h00, 1'b0);
		expect_buttons(7'b0000001);
		set_joy(8'h00, 8'h01, 1'b0);
		expect_buttons(7'b0001000);
		// plain mapping
		set_joy(8'h04, 8'h00, 1'b1);
		expect_buttons(7'b0001000);
		set_joy(8'h00, 8'h02, 1'b1);
		expect_buttons(7'b0000010);
		set_joy(8'h01, 8'h00, 1'b1);
		expect_buttons(7'b0000001);
		set_joy(8'h08, 8'h00, 1'b1);
		expect_buttons(7'b0000000);
		set_joy(8'h10, 8'h00, 1'b1);
		expect_buttons(7'b0000100);
		set_joy(8'h00, 8'h00, 1'b1);
		set_key(KEY_LEFT, 1'b1);
		expect_buttons(7'b0000010);
		set_key(KEY_LEFT, 1'b0);
		set_joy(8'h00, 8'h00, 1'b0);
		set_key(KEY_FIRE, 1'b1);
		expect_buttons(7'b0000100);
		set_key(KEY_FIRE, 1'b0);
		set_key(KEY_COIN, 1'b1);
		expect_buttons(7'b1000000);
		set_key(KEY_COIN, 1'b0);
		set_key(KEY_START1, 1'b1);
		expect_buttons(7'b0100000);
		set_key(KEY_START1, 1'b0);
		set_key(KEY_START2, 1'b1);
		expect_buttons(7'b0010000);
		set_key(KEY_START2, 1'b0);
		expect_buttons(7'b0000000);
	endtask

	// ones over one full accumulator period equal the sample
	task automatic test_audio();
		int ones_l;
		int ones_r;
		audio_l_in = sample_t'(12345);
		audio_r_in = sample_t'(40000);
		apply_reset();
		ones_l = 0;
		ones_r = 0;
		for (int n = 0; n < 65536; n++) begin
			@(negedge clk_sys);
			ones_l += int'(audio_l);
			ones_r += int'(audio_r);
		end
		check_count("ones on audio_l", sample_t'(ones_l), sample_t'(12345));
		check_count("ones on audio_r", sample_t'(ones_r), sample_t'(40000));
	endtask

	initial begin
		rng_state = 32'd11969;
		rst = 1'b1;
		user_reset = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		cpu_rom_addr = '0;
		cpu_rom_rd = 1'b0;
		snd_rom_addr = '0;
		snd_rom_rd = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		rotate = 1'b0;
		audio_l_in = '0;
		audio_r_in = '0;
		apply_reset();
		test_reset_hold();
		test_cpu_read();
		test_snd_offset();
		test_repeat_addr();
		test_controls();
		test_audio();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- kickman_glue.f
kickman_glue_pkg.sv
rom_port_if.sv
rom_access_ctrl.sv
rom_store.sv
control_mapper.sv
sigma_delta_dac.sv
kickman_glue_top.sv
kickman_glue_asserts.sv
tb_kickman_glue.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide the result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
	--top-module tb_kickman_glue -f kickman_glue.f; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_kickman_glue > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "simulation finished without failure"
exit 0
